/* hdl/uart_bridge_cfg.svh */
`ifndef UART_BRIDGE_CFG_SVH
`define UART_BRIDGE_CFG_SVH

// serial timing
// clocks per serial bit, kept short for simulation
`define UB_CLKS_PER_BIT 8
// spacing of transmit strobes, a full frame plus slack
`define UB_BYTE_GAP (10 * `UB_CLKS_PER_BIT + 4)

// burst shape
`define UB_BURST_WORDS 4
`define UB_BURST_BYTES 16

// word memory
`define UB_MEM_DEPTH 256

// command opcodes
// ascii 'W'
`define UB_OP_WRITE 8'h57
// ascii 'R'
`define UB_OP_READ 8'h52

`endif

/* hdl/uart_bridge_pkg.sv */
package uart_bridge_pkg;

    // one serial byte
    typedef logic [7:0] byte_t;
    // word address into the burst memory
    typedef logic [7:0] word_addr_t;
    // memory word, four bytes
    typedef logic [31:0] mem_word_t;

    // parser fsm
    typedef enum logic [1:0] {
        PS_IDLE,
        PS_WR_ADDR,
        PS_WR_DATA,
        PS_RD_ADDR
    } parse_state_t;

    // record kinds from parser to burst stage
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_WR_START,
        CMD_WR_BYTE,
        CMD_RD_START
    } cmd_kind_t;

    // addr valid on start records, data on byte records
    typedef struct packed {
        cmd_kind_t  kind;
        word_addr_t addr;
        byte_t      data;
    } cmd_t;

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/1ns
`include "uart_bridge_cfg.svh"

module uart_rx
    import uart_bridge_pkg::*;
(
    input  logic  clk1,
    input  logic  rst_n,
    input  logic  rx_line,
    output byte_t rx_byte,
    output logic  rx_valid
);

    localparam int CNT_W = $clog2(`UB_CLKS_PER_BIT);
    localparam int HALF  = `UB_CLKS_PER_BIT / 2;

    // two-flop sync plus one for edge detect
    logic             rx_sync1;
    logic             rx_sync2;
    logic             rx_prev;
    logic             busy;
    // cycles left to next sample point
    logic [CNT_W-1:0] cyc_cnt;
    // 0 start, 1..8 data, 9 stop
    logic [3:0]       bit_cnt;
    byte_t            shift_reg;

    assign rx_byte = shift_reg;

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            rx_sync1 <= 1'b1;
            rx_sync2 <= 1'b1;
            rx_prev  <= 1'b1;
            busy     <= 1'b0;
            cyc_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync1 <= rx_line;
            rx_sync2 <= rx_sync1;
            rx_prev  <= rx_sync2;
            rx_valid <= 1'b0;
            if (!busy) begin
                // falling edge, first sample half a bit later
                if (rx_prev && !rx_sync2) begin
                    busy    <= 1'b1;
                    cyc_cnt <= CNT_W'(HALF - 1);
                    bit_cnt <= '0;
                end
            end else if (cyc_cnt != '0) begin
                cyc_cnt <= cyc_cnt - 1'b1;
            end else begin
                // mid-bit sample
                cyc_cnt <= CNT_W'(`UB_CLKS_PER_BIT - 1);
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0) begin
                    // glitch, start bit gone by mid-period
                    busy <= !rx_sync2;
                end else if (bit_cnt == 4'd9) begin
                    // stop bit, framing error drops the byte
                    busy     <= 1'b0;
                    rx_valid <= rx_sync2;
                end
            end
        end
    end

    // data bits, lsb first
    always_ff @(posedge clk1) begin
        if (busy && cyc_cnt == '0 && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_reg <= {rx_sync2, shift_reg[7:1]};
        end
    end

    // byte strobe is a single-cycle pulse
    assert property (@(posedge clk1) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

/* hdl/cmd_parser.sv */
`timescale 1ns/1ns
`include "uart_bridge_cfg.svh"

module cmd_parser
    import uart_bridge_pkg::*;
(
    input  logic  clk1,
    input  logic  rst_n,
    input  byte_t rx_byte,
    input  logic  rx_valid,
    output cmd_t  cmd
);

    // one spare bit so an overrun is visible
    localparam int CNT_W = $clog2(`UB_BURST_BYTES) + 1;

    parse_state_t     state;
    // data bytes taken so far in this burst
    logic [CNT_W-1:0] data_cnt;

    //////////////////////////////////////////////////
    // command fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            state    <= PS_IDLE;
            data_cnt <= '0;
            cmd.kind <= CMD_NONE;
        end else begin
            // records last one cycle
            cmd.kind <= CMD_NONE;
            if (rx_valid) begin
                case (state)
                    PS_IDLE: begin
                        // unknown opcodes fall through
                        if (rx_byte == `UB_OP_WRITE) begin
                            state <= PS_WR_ADDR;
                        end else if (rx_byte == `UB_OP_READ) begin
                            state <= PS_RD_ADDR;
                        end
                    end
                    PS_WR_ADDR: begin
                        // addr field holds through the byte records
                        cmd.kind <= CMD_WR_START;
                        cmd.addr <= rx_byte;
                        data_cnt <= '0;
                        state    <= PS_WR_DATA;
                    end
                    PS_WR_DATA: begin
                        cmd.kind <= CMD_WR_BYTE;
                        cmd.data <= rx_byte;
                        if (data_cnt == CNT_W'(`UB_BURST_BYTES - 1)) begin
                            data_cnt <= '0;
                            state    <= PS_IDLE;
                        end else begin
                            data_cnt <= data_cnt + 1'b1;
                        end
                    end
                    PS_RD_ADDR: begin
                        cmd.kind <= CMD_RD_START;
                        cmd.addr <= rx_byte;
                        state    <= PS_IDLE;
                    end
                    default: begin
                        state <= PS_IDLE;
                    end
                endcase
            end
        end
    end

    // count only runs inside a data phase and stays below a burst
    assert property (@(posedge clk1) disable iff (!rst_n)
        (data_cnt != '0) |-> (state == PS_WR_DATA && data_cnt < CNT_W'(`UB_BURST_BYTES)));

endmodule

/* hdl/burst_store.sv */
`timescale 1ns/1ns
`include "uart_bridge_cfg.svh"

module burst_store
    import uart_bridge_pkg::*;
(
    input  logic  clk1,
    input  logic  rst_n,
    input  cmd_t  cmd,
    output byte_t tx_byte,
    output logic  tx_start,
    output logic  wr_over
);

    localparam int WORD_BYTES = `UB_BURST_BYTES / `UB_BURST_WORDS;
    localparam int IDX_W      = $clog2(`UB_BURST_BYTES);
    localparam int SEL_W      = $clog2(WORD_BYTES);
    localparam int LEFT_W     = IDX_W + 1;
    localparam int GAP_W      = $clog2(`UB_BYTE_GAP);
    localparam int BYTE_W     = $bits(byte_t);

    mem_word_t         mem [`UB_MEM_DEPTH];

    // write side
    word_addr_t        wr_base;
    logic [IDX_W-1:0]  wr_byte_cnt;
    mem_word_t         word_asm;
    mem_word_t         wr_word;
    logic              wr_word_done;
    word_addr_t        wr_addr;

    // read side
    word_addr_t        rd_base;
    logic [LEFT_W-1:0] rd_left;
    logic [IDX_W-1:0]  rd_idx;
    logic [GAP_W-1:0]  gap_cnt;
    mem_word_t         rd_word;
    logic              rd_fire;
    logic              rd_start_ok;

    //////////////////////////////////////////////////
    // write burst
    //////////////////////////////////////////////////

    // first byte shifts down to the lsb
    assign wr_word      = {cmd.data, word_asm[$bits(mem_word_t)-1:BYTE_W]};
    assign wr_word_done = (cmd.kind == CMD_WR_BYTE) &&
                          (wr_byte_cnt[SEL_W-1:0] == SEL_W'(WORD_BYTES - 1));
    // wraps at the top of memory
    assign wr_addr      = wr_base + word_addr_t'(wr_byte_cnt[IDX_W-1:SEL_W]);

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            wr_byte_cnt <= '0;
            wr_over     <= 1'b0;
        end else if (cmd.kind == CMD_WR_START) begin
            wr_byte_cnt <= '0;
            wr_over     <= 1'b0;
        end else if (cmd.kind == CMD_WR_BYTE) begin
            wr_byte_cnt <= wr_byte_cnt + 1'b1;
            // last byte of the burst lights the led
            if (wr_byte_cnt == IDX_W'(`UB_BURST_BYTES - 1)) begin
                wr_over <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk1) begin
        if (cmd.kind == CMD_WR_START) begin
            wr_base <= cmd.addr;
        end
        if (cmd.kind == CMD_WR_BYTE) begin
            word_asm <= wr_word;
        end
        if (wr_word_done) begin
            mem[wr_addr] <= wr_word;
        end
    end

    //////////////////////////////////////////////////
    // read burst and byte pacing
    //////////////////////////////////////////////////

    // countdown 16..1 maps to byte 0..15
    assign rd_idx      = IDX_W'(LEFT_W'(`UB_BURST_BYTES) - rd_left);
    assign rd_word     = mem[rd_base + word_addr_t'(rd_idx[IDX_W-1:SEL_W])];
    assign rd_fire     = (rd_left != '0) && (gap_cnt == '0);
    // no restart while a readback runs
    assign rd_start_ok = (cmd.kind == CMD_RD_START) && (rd_left == '0);

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            rd_left  <= '0;
            gap_cnt  <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= rd_fire;
            if (rd_start_ok) begin
                rd_left <= LEFT_W'(`UB_BURST_BYTES);
            end else if (rd_fire) begin
                rd_left <= rd_left - 1'b1;
            end
            // gap restarts on every strobe
            if (rd_fire) begin
                gap_cnt <= GAP_W'(`UB_BYTE_GAP - 1);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk1) begin
        if (rd_start_ok) begin
            rd_base <= cmd.addr;
        end
        if (rd_fire) begin
            tx_byte <= rd_word[BYTE_W*rd_idx[SEL_W-1:0] +: BYTE_W];
        end
    end

    // strobes inside a readback stay one byte gap apart
    assert property (@(posedge clk1) disable iff (!rst_n)
        (tx_start && $past(rd_left) != LEFT_W'(`UB_BURST_BYTES)) |->
            $past(tx_start, `UB_BYTE_GAP));

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ns
`include "uart_bridge_cfg.svh"

module uart_tx
    import uart_bridge_pkg::*;
(
    input  logic  clk1,
    input  logic  rst_n,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  tx_line
);

    localparam int CNT_W   = $clog2(`UB_CLKS_PER_BIT);
    // start, eight data, stop
    localparam int FRAME_W = 10;

    // line is always the frame lsb, ones idle high
    logic [FRAME_W-1:0] frame;
    logic [CNT_W-1:0]   cyc_cnt;
    logic [3:0]         bit_cnt;
    logic               busy;

    assign tx_line = frame[0];

    always_ff @(posedge clk1) begin
        if (!rst_n) begin
            frame   <= '1;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
        end else if (tx_start) begin
            // start bit goes out next cycle
            frame   <= {1'b1, tx_byte, 1'b0};
            cyc_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b1;
        end else if (busy) begin
            if (cyc_cnt == CNT_W'(`UB_CLKS_PER_BIT - 1)) begin
                cyc_cnt <= '0;
                // shift in idle ones behind the frame
                frame   <= {1'b1, frame[FRAME_W-1:1]};
                if (bit_cnt == 4'(FRAME_W - 1)) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // upstream gap must cover a whole frame
    assert property (@(posedge clk1) disable iff (!rst_n) tx_start |-> !busy);

endmodule

/* hdl/uart_bridge_top.sv */
`timescale 1ns/1ns

module uart_bridge_top
    import uart_bridge_pkg::*;
(
    input  logic clk1,
    input  logic rst_n,
    input  logic uart_rx_line,
    output logic uart_tx_line,
    output logic wr_over_led
);

    // receiver to parser
    byte_t rx_byte;
    logic  rx_valid;
    // parser to burst stage
    cmd_t  cmd;
    // burst stage to transmitter
    byte_t tx_byte;
    logic  tx_start;

    //////////////////////////////////////////////////
    // rx -> parser -> store -> tx
    //////////////////////////////////////////////////

    uart_rx rx0 (
        .clk1     (clk1),
        .rst_n    (rst_n),
        .rx_line  (uart_rx_line),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_parser parser0 (
        .clk1     (clk1),
        .rst_n    (rst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cmd      (cmd)
    );

    burst_store store0 (
        .clk1     (clk1),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .wr_over  (wr_over_led)
    );

    uart_tx tx0 (
        .clk1     (clk1),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_line  (uart_tx_line)
    );

endmodule

/* dv/tb_uart_bridge.sv */
`timescale 1ns/1ns
`include "uart_bridge_cfg.svh"

module tb_uart_bridge
    import uart_bridge_pkg::*;
();

    localparam int CLKS       = `UB_CLKS_PER_BIT;
    localparam int BURST      = `UB_BURST_BYTES;
    localparam int WORD_BYTES = `UB_BURST_BYTES / `UB_BURST_WORDS;
    localparam int REF_SIZE   = `UB_MEM_DEPTH * WORD_BYTES;
    // whole readback plus slack for the command frames
    localparam int READ_LIMIT = BURST * `UB_BYTE_GAP + 400;

    logic clk1;
    logic rst_n;
    logic uart_rx_line;
    wire  uart_tx_line;
    wire  wr_over_led;

    // reference memory, one entry per byte, flag marks written bytes
    byte_t ref_mem [REF_SIZE];
    bit    ref_valid [REF_SIZE];
    // bytes seen on the serial output
    byte_t rx_q [$];
    int    seed = 48;
    int    errors;
    int    checks;
    int    tests_done;
    int    start_errors;

    // serial output monitor state
    bit    mon_busy;
    int    mon_cnt;
    byte_t mon_shift;

    uart_bridge_top dut0 (
        .clk1         (clk1),
        .rst_n        (rst_n),
        .uart_rx_line (uart_rx_line),
        .uart_tx_line (uart_tx_line),
        .wr_over_led  (wr_over_led)
    );

    initial clk1 = 1'b0;
    always #5 clk1 = ~clk1;

    //////////////////////////////////////////////////
    // serial monitor, sampled on the falling edge
    //////////////////////////////////////////////////

    task sample_tx_line();
        if (!rst_n) begin
            mon_busy = 1'b0;
        end else if (!mon_busy) begin
            // first low half a cycle into the start bit
            if (uart_tx_line === 1'b0) begin
                mon_busy = 1'b1;
                mon_cnt  = 0;
            end
        end else begin
            mon_cnt++;
            // mid-bit points of data and stop bits
            if (mon_cnt % CLKS == CLKS / 2) begin
                if (mon_cnt / CLKS >= 1 && mon_cnt / CLKS <= 8) begin
                    mon_shift = {uart_tx_line, mon_shift[7:1]};
                end else if (mon_cnt / CLKS == 9) begin
                    mon_busy = 1'b0;
                    if (uart_tx_line !== 1'b1) begin
                        errors++;
                        $display("framing error at %0t, stop bit low on the serial output", $time);
                    end else begin
                        rx_q.push_back(mon_shift);
                    end
                end
            end
        end
    endtask

    always @(negedge clk1) sample_tx_line();

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_line = frame[i];
            repeat (CLKS) @(posedge clk1);
            #1;
        end
    endtask

    // byte i of a burst lands in word base + i/4, first byte lowest
    function automatic int ref_index(input word_addr_t base, input int idx);
        int word;
        word = (int'(base) + idx / WORD_BYTES) % `UB_MEM_DEPTH;
        return word * WORD_BYTES + idx % WORD_BYTES;
    endfunction

    task automatic send_write_data(input word_addr_t addr);
        byte_t b;
        for (int i = 0; i < BURST; i++) begin
            b = byte_t'($random(seed));
            ref_mem[ref_index(addr, i)]   = b;
            ref_valid[ref_index(addr, i)] = 1'b1;
            send_byte(b);
        end
    endtask

    task automatic send_write(input word_addr_t addr);
        send_byte(`UB_OP_WRITE);
        send_byte(addr);
        send_write_data(addr);
    endtask

    task automatic wait_rx_count(input int n, input int limit);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < limit) begin
            @(posedge clk1);
            #1;
            cyc++;
        end
        if (rx_q.size() < n) begin
            errors++;
            $display("timeout: only %0d of %0d bytes came back on the serial output",
                     rx_q.size(), n);
        end
    endtask

    task automatic wait_led(input logic level, input int limit);
        int cyc;
        cyc = 0;
        while (wr_over_led !== level && cyc < limit) begin
            @(posedge clk1);
            #1;
            cyc++;
        end
        if (wr_over_led !== level) begin
            errors++;
            $display("timeout: write-over LED never went to %0b", level);
        end
    endtask

    // read command, then compare every byte the model knows
    task automatic check_read(input word_addr_t addr, input string tag);
        int idx;
        rx_q.delete();
        send_byte(`UB_OP_READ);
        send_byte(addr);
        wait_rx_count(BURST, READ_LIMIT);
        for (int i = 0; i < BURST && i < rx_q.size(); i++) begin
            idx = ref_index(addr, i);
            if (ref_valid[idx]) begin
                check_value(32'(rx_q[i]), 32'(ref_mem[idx]), $sformatf("%s byte %0d", tag, i));
            end
        end
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("test %0d %-16s %s", tests_done, name,
                 (errors == start_errors) ? "ok" : "had errors");
        start_errors = errors;
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial begin
        int low_cycles;
        uart_rx_line = 1'b1;
        rst_n        = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_done   = 0;
        start_errors = 0;
        for (int i = 0; i < REF_SIZE; i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk1);
        #1;
        rst_n = 1'b1;

        // quiet outputs after reset
        low_cycles = 0;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk1);
            if (uart_tx_line !== 1'b1 || wr_over_led !== 1'b0) begin
                low_cycles++;
            end
        end
        check_value(32'(low_cycles), 0, "cycles with active outputs after reset");
        @(posedge clk1);
        #1;
        report_test("idle");

        send_write(8'h10);
        check_read(8'h10, "read 0x10");
        report_test("write_read");

        // led still lit from the last burst, opcode alone keeps it
        check_value(32'(wr_over_led), 1, "led after a full burst");
        send_byte(`UB_OP_WRITE);
        check_value(32'(wr_over_led), 1, "led after write opcode");
        send_byte(8'h20);
        wait_led(1'b0, 4 * CLKS);
        send_write_data(8'h20);
        wait_led(1'b1, 4 * CLKS);
        report_test("write_over_led");

        // words 0x22 and 0x23 get overwritten
        send_write(8'h22);
        check_read(8'h20, "read 0x20");
        report_test("overlap");

        send_write(8'hfe);
        check_read(8'hfe, "read 0xfe");
        check_read(8'h00, "read 0x00");
        report_test("addr_wrap");

        // a dropped opcode must leave the line idle for a whole burst
        rx_q.delete();
        send_byte(8'h41);
        low_cycles = 0;
        for (int i = 0; i < BURST * `UB_BYTE_GAP; i++) begin
            @(negedge clk1);
            if (uart_tx_line !== 1'b1) begin
                low_cycles++;
            end
        end
        @(posedge clk1);
        #1;
        check_value(32'(low_cycles), 0, "serial output cycles after unknown opcode");
        check_value(32'(rx_q.size()), 0, "bytes after unknown opcode");
        check_read(8'h10, "read after unknown");
        report_test("unknown_opcode");

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        #1000000;
        $display("timeout: simulation did not reach the end of the tests");
        $display("Regression failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/uart_bridge_pkg.sv
hdl/uart_rx.sv
hdl/cmd_parser.sv
hdl/burst_store.sv
hdl/uart_tx.sv
hdl/uart_bridge_top.sv
dv/tb_uart_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the bridge regression with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_uart_bridge -o sim_uart_bridge
./obj_dir/sim_uart_bridge > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
